// File: test/demodTopPatterns.txt
# op addr data: W write, R read and compare, C idle cycles (hex), K clock read
# addr is the 12-bit word address in hex, data and expected values are hex half-words
R 024 0000
R 025 0185
R 02C 0002
R 02D 0000
R 000 0000
R 0A1 0000
R 040 5678
R 041 1234
R 060 DEF0
R 061 9ABC
R 080 2D3C
R 081 0F1E
W 028 0000
C 0A
K 028
K 029
C 20
W 028 0000
C 03
K 028
R 029 0000
W 030 BEEF
W 031 0012
R 030 BEEF
R 031 0012
R 020 0000

// File: src.f
hw/demodPkg.sv
hw/hostDecode.sv
hw/miscRegs.sv
hw/trellisRouter.sv
hw/dacChannel.sv
hw/demodTop.sv
test/demodTopTb.sv

// File: Makefile
all: run

obj_dir/VdemodTopTb: src.f hw/*.sv test/demodTopTb.sv
	verilator --binary --timing --assert --top-module demodTopTb -f src.f

run: obj_dir/VdemodTopTb
	obj_dir/VdemodTopTb

lint:
	verilator --lint-only --timing --top-module demodTopTb -f src.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: test/demodTopTb.sv
// Demodulator glue testbench
`timescale 1ns/1ps

module demodTopTb;

    localparam logic [11:0] CLOCK_LO = {demodPkg::MISC_SPACE, demodPkg::MISC_CLOCK, 1'b0};
    localparam logic [11:0] RESET_LO = {demodPkg::MISC_SPACE, demodPkg::MISC_RESET, 1'b0};
    localparam logic [11:0] BOOT_LO  = {demodPkg::MISC_SPACE, demodPkg::REBOOT_ADDR, 1'b0};
    localparam logic [11:0] BOOT_HI  = {demodPkg::MISC_SPACE, demodPkg::REBOOT_ADDR, 1'b1};
    localparam int CLK_PERIOD = 20;

    logic clk;
    logic clockCounterEn;
    demodPkg::hostAddrT addr;
    demodPkg::hostDataT wrData;
    logic wrEn;
    logic rdEn;
    demodPkg::hostDataT rdData;
    demodPkg::regWordT demodRdData;
    demodPkg::regWordT trellisRdData;
    demodPkg::regWordT sdiRdData;
    demodPkg::demodModeT demodMode;
    logic trellisSymSync, iSymEn, iSym2xEn, iBit, qBit, auBit;
    logic carrierLock, bitsyncLock;
    demodPkg::symbolT iSymData, qSymData;
    logic multihLoopEn, multihLoop2xEn, multihDemodLock;
    demodPkg::symbolT iMultihLoop, qMultihLoop;
    logic [2:0] demodSync, multihDacSync, multihDacEn;
    demodPkg::symbolT demodData [3];
    demodPkg::symbolT multihDacData [3];
    logic multihSymEn, multihSym2xEn, trellisSymEn, trellisSym2xEn;
    demodPkg::symbolT iMultihIn, qMultihIn, iTrellis, qTrellis;
    logic legacyBit, iData, qData, dataSymEn, dataSym2xEn, bsyncNLock, demodNLock;
    demodPkg::dacWordT dacData [3];
    logic [2:0] dacSync;
    demodPkg::bootAddrT rebootAddr;
    logic rebootPulse;
    logic coreReset;

    // Pattern store
    byte opQ[$];
    logic [31:0] argAQ[$];
    logic [31:0] argBQ[$];
    logic loaded = 1'b0;

    int edgeNum = 0;
    int restartEdge = 0;
    logic [31:0] clockHold = '0;
    logic [23:0] bootModel = '0;
    demodPkg::dacWordT dacModel [3];
    logic [17:0] lfsrState = 18'd87;

    demodTop DUT (
        .clk(clk), .clockCounterEn(clockCounterEn),
        .addr(addr), .wrData(wrData), .wrEn(wrEn), .rdEn(rdEn), .rdData(rdData),
        .demodRdData(demodRdData), .trellisRdData(trellisRdData), .sdiRdData(sdiRdData),
        .demodMode(demodMode),
        .trellisSymSync(trellisSymSync), .iSymEn(iSymEn), .iSym2xEn(iSym2xEn),
        .iBit(iBit), .qBit(qBit), .auBit(auBit),
        .carrierLock(carrierLock), .bitsyncLock(bitsyncLock),
        .iSymData(iSymData), .qSymData(qSymData),
        .multihLoopEn(multihLoopEn), .multihLoop2xEn(multihLoop2xEn),
        .multihDemodLock(multihDemodLock),
        .iMultihLoop(iMultihLoop), .qMultihLoop(qMultihLoop),
        .demod0Sync(demodSync[0]), .demod0Data(demodData[0]),
        .multihDac0Sync(multihDacSync[0]), .multihDac0Data(multihDacData[0]),
        .multihDac0En(multihDacEn[0]),
        .demod1Sync(demodSync[1]), .demod1Data(demodData[1]),
        .multihDac1Sync(multihDacSync[1]), .multihDac1Data(multihDacData[1]),
        .multihDac1En(multihDacEn[1]),
        .demod2Sync(demodSync[2]), .demod2Data(demodData[2]),
        .multihDac2Sync(multihDacSync[2]), .multihDac2Data(multihDacData[2]),
        .multihDac2En(multihDacEn[2]),
        .multihSymEn(multihSymEn), .multihSym2xEn(multihSym2xEn),
        .iMultihIn(iMultihIn), .qMultihIn(qMultihIn),
        .trellisSymEn(trellisSymEn), .trellisSym2xEn(trellisSym2xEn),
        .iTrellis(iTrellis), .qTrellis(qTrellis), .legacyBit(legacyBit),
        .iData(iData), .qData(qData), .dataSymEn(dataSymEn), .dataSym2xEn(dataSym2xEn),
        .bsyncNLock(bsyncNLock), .demodNLock(demodNLock),
        .dac0Data(dacData[0]), .dac1Data(dacData[1]), .dac2Data(dacData[2]),
        .dac0Sync(dacSync[0]), .dac1Sync(dacSync[1]), .dac2Sync(dacSync[2]),
        .rebootAddr(rebootAddr), .rebootPulse(rebootPulse), .coreReset(coreReset)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Edge index for the clock read model
    always @(posedge clk) begin
        edgeNum <= edgeNum + 1;
    end

    //************************************************************************
    // Helpers
    //************************************************************************

    // x^18 + x^11 + 1
    function automatic logic stepLfsr();
        logic fb;
        fb = lfsrState[17] ^ lfsrState[10];
        lfsrState = {lfsrState[16:0], fb};
        return fb;
    endfunction

    function automatic demodPkg::symbolT randSym();
        demodPkg::symbolT v;
        v = '0;
        for (int i = 0; i < 18; i++) begin
            v = {v[16:0], stepLfsr()};
        end
        return v;
    endfunction

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail %s got %h expected %h", name, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic hostWrite(logic [11:0] a, logic [15:0] d);
        @(posedge clk);
        addr <= a;
        wrData <= d;
        wrEn <= 1'b1;
        if (a[11:1] == CLOCK_LO[11:1]) begin
            restartEdge = edgeNum + 1;
        end
        if (a == BOOT_LO) begin
            bootModel[15:0] = d;
        end
        if (a == BOOT_HI) begin
            bootModel[23:16] = d[7:0];
        end
        @(posedge clk);
        wrEn <= 1'b0;
        @(negedge clk);
        checkValue("rebootPulse", 32'(rebootPulse), 32'(a == BOOT_HI));
        if (a == BOOT_HI) begin
            checkValue("rebootAddr", 32'(rebootAddr), 32'(bootModel));
        end
        @(negedge clk);
        checkValue("rebootPulse", 32'(rebootPulse), 32'h0);
    endtask

    // Returns the read value and the index of the sampling edge
    task automatic hostRead(logic [11:0] a, output logic [15:0] got, output int sampleEdge);
        @(posedge clk);
        addr <= a;
        rdEn <= 1'b1;
        @(posedge clk);
        sampleEdge = edgeNum;
        rdEn <= 1'b0;
        @(negedge clk);
        got = rdData;
    endtask

    // Soft reset stretch after a MISC_RESET read
    task automatic checkCoreReset();
        checkValue("coreReset", 32'(coreReset), 32'h0);
        for (int i = 0; i < demodPkg::RESET_STRETCH; i++) begin
            @(negedge clk);
            checkValue("coreReset", 32'(coreReset), 32'h1);
        end
        @(negedge clk);
        checkValue("coreReset", 32'(coreReset), 32'h0);
    endtask

    task automatic routerCheck(demodPkg::demodModeT mode);
        logic mh;
        logic fm;
        logic aq;
        mh = (mode == demodPkg::MODE_MULTIH);
        fm = (mode == demodPkg::MODE_FM) || (mode == demodPkg::MODE_2FSK);
        aq = (mode == demodPkg::MODE_AQPSK) || (mode == demodPkg::MODE_AUQPSK);
        for (int n = 0; n < 6; n++) begin
            @(posedge clk);
            demodMode <= mode;
            trellisSymSync <= stepLfsr();
            iSymEn <= stepLfsr();
            iSym2xEn <= stepLfsr();
            iBit <= stepLfsr();
            qBit <= stepLfsr();
            auBit <= stepLfsr();
            carrierLock <= stepLfsr();
            bitsyncLock <= stepLfsr();
            multihLoopEn <= stepLfsr();
            multihLoop2xEn <= stepLfsr();
            multihDemodLock <= stepLfsr();
            iSymData <= randSym();
            qSymData <= randSym();
            iMultihLoop <= randSym();
            qMultihLoop <= randSym();
            @(posedge clk);
            @(negedge clk);
            checkValue("multihSymEn", 32'(multihSymEn), 32'(trellisSymSync & mh));
            checkValue("multihSym2xEn", 32'(multihSym2xEn), 32'(iSym2xEn & mh));
            checkValue("iMultihIn", 32'(iMultihIn), 32'(iSymData));
            checkValue("qMultihIn", 32'(qMultihIn), 32'(qSymData));
            checkValue("trellisSymEn", 32'(trellisSymEn),
                32'(mh ? multihLoopEn : trellisSymSync));
            checkValue("trellisSym2xEn", 32'(trellisSym2xEn),
                32'(mh ? multihLoop2xEn : iSym2xEn));
            checkValue("iTrellis", 32'(iTrellis), 32'(mh ? iMultihLoop : iSymData));
            checkValue("qTrellis", 32'(qTrellis), 32'(mh ? qMultihLoop : qSymData));
            checkValue("legacyBit", 32'(legacyBit), 32'(iBit));
            checkValue("iData", 32'(iData), 32'(fm ? !iBit : iBit));
            checkValue("qData", 32'(qData), 32'(aq ? auBit : qBit));
            checkValue("dataSymEn", 32'(dataSymEn), 32'(iSymEn));
            checkValue("dataSym2xEn", 32'(dataSym2xEn), 32'(iSym2xEn));
            checkValue("bsyncNLock", 32'(bsyncNLock), 32'(!bitsyncLock));
            checkValue("demodNLock", 32'(demodNLock),
                32'(mh ? !multihDemodLock : !carrierLock));
        end
    endtask

    task automatic dacCheck(demodPkg::demodModeT mode);
        logic expSync [3];
        logic useMh;
        demodPkg::symbolT src;
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            demodMode <= mode;
            for (int c = 0; c < 3; c++) begin
                demodSync[c] <= stepLfsr();
                multihDacSync[c] <= stepLfsr();
                multihDacEn[c] <= stepLfsr();
                demodData[c] <= randSym();
                multihDacData[c] <= randSym();
            end
            @(posedge clk);
            for (int c = 0; c < 3; c++) begin
                useMh = (mode == demodPkg::MODE_MULTIH) && multihDacEn[c];
                src = useMh ? multihDacData[c] : demodData[c];
                expSync[c] = useMh ? multihDacSync[c] : demodSync[c];
                if (expSync[c]) begin
                    dacModel[c] = src[17:demodPkg::DAC_LSB];
                end
                demodSync[c] <= 1'b0;
                multihDacSync[c] <= 1'b0;
                demodData[c] <= randSym();
                multihDacData[c] <= randSym();
            end
            @(negedge clk);
            for (int c = 0; c < 3; c++) begin
                checkValue($sformatf("dac%0dSync", c), 32'(dacSync[c]), 32'(expSync[c]));
            end
            // New word lands and then holds while sync is low
            repeat (2) begin
                @(negedge clk);
                for (int c = 0; c < 3; c++) begin
                    checkValue($sformatf("dac%0dData", c), 32'(dacData[c]), 32'(dacModel[c]));
                end
            end
        end
    endtask

    //************************************************************************
    // Main sequence
    //************************************************************************

    initial begin
        int fd;
        string line;
        byte op;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] got;
        int sampleEdge;
        logic [31:0] count;
        demodPkg::demodModeT modes [7];

        modes = '{demodPkg::MODE_FM, demodPkg::MODE_2FSK, demodPkg::MODE_AQPSK,
                  demodPkg::MODE_AUQPSK, demodPkg::MODE_PCMTRELLIS,
                  demodPkg::MODE_SOQPSK, demodPkg::MODE_MULTIH};
        clockCounterEn = 1'b1;
        addr = '0;
        wrData = '0;
        wrEn = 1'b0;
        rdEn = 1'b0;
        demodRdData = 32'h1234_5678;
        trellisRdData = 32'h9ABC_DEF0;
        sdiRdData = 32'h0F1E_2D3C;
        demodMode = demodPkg::MODE_FM;
        {trellisSymSync, iSymEn, iSym2xEn, iBit, qBit, auBit} = '0;
        {carrierLock, bitsyncLock, multihLoopEn, multihLoop2xEn, multihDemodLock} = '0;
        iSymData = '0;
        qSymData = '0;
        iMultihLoop = '0;
        qMultihLoop = '0;
        demodSync = '0;
        multihDacSync = '0;
        multihDacEn = '0;
        for (int c = 0; c < 3; c++) begin
            demodData[c] = '0;
            multihDacData[c] = '0;
            dacModel[c] = '0;
        end

        fd = $fopen("test/demodTopPatterns.txt", "r");
        if (fd == 0) begin
            $display("SIMULATION FAILED");
            $fatal(1, "cannot open the pattern file test/demodTopPatterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                a = '0;
                b = '0;
                void'($sscanf(line, "%c %h %h", op, a, b));
                opQ.push_back(op);
                argAQ.push_back(a);
                argBQ.push_back(b);
            end
        end
        $fclose(fd);
        loaded = 1'b1;

        repeat (10) @(posedge clk);
        clockCounterEn <= 1'b0;

        foreach (opQ[i]) begin
            a = argAQ[i];
            b = argBQ[i];
            case (opQ[i])
                "W": hostWrite(a[11:0], b[15:0]);
                "C": begin
                    count = a;
                    repeat (count) @(posedge clk);
                end
                "R": begin
                    hostRead(a[11:0], got, sampleEdge);
                    checkValue($sformatf("rdData@%03h", a[11:0]), 32'(got), 32'(b[15:0]));
                    if (a[11:1] == RESET_LO[11:1]) begin
                        checkCoreReset();
                    end
                end
                "K": begin
                    hostRead(a[11:0], got, sampleEdge);
                    if (a[0]) begin
                        checkValue("rdData clock high", 32'(got), 32'(clockHold[31:16]));
                    end else begin
                        clockHold = 32'(sampleEdge - restartEdge - 1);
                        checkValue("rdData clock low", 32'(got), 32'(clockHold[15:0]));
                    end
                end
                default: begin
                    $display("SIMULATION FAILED");
                    $fatal(1, "unknown opcode in pattern line %0d", i);
                end
            endcase
        end

        foreach (modes[m]) begin
            routerCheck(modes[m]);
        end
        dacCheck(demodPkg::MODE_SOQPSK);
        dacCheck(demodPkg::MODE_MULTIH);

        $display("SIMULATION PASSED");
        $finish;
    end

    // Run limit scales with the pattern count
    initial begin
        wait (loaded);
        #((opQ.size() * 50 + 2000) * CLK_PERIOD);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout, the run did not finish in time");
    end

endmodule

// File: hw/demodTop.sv
// Demodulator board glue top
`timescale 1ns/1ps

module demodTop (
    input  logic                clk,
    input  logic                clockCounterEn,
    input  demodPkg::hostAddrT  addr,
    input  demodPkg::hostDataT  wrData,
    input  logic                wrEn,
    input  logic                rdEn,
    output demodPkg::hostDataT  rdData,
    input  demodPkg::regWordT   demodRdData,
    input  demodPkg::regWordT   trellisRdData,
    input  demodPkg::regWordT   sdiRdData,
    input  demodPkg::demodModeT demodMode,
    input  logic                trellisSymSync,
    input  logic                iSymEn,
    input  logic                iSym2xEn,
    input  logic                iBit,
    input  logic                qBit,
    input  logic                auBit,
    input  logic                carrierLock,
    input  logic                bitsyncLock,
    input  demodPkg::symbolT    iSymData,
    input  demodPkg::symbolT    qSymData,
    input  logic                multihLoopEn,
    input  logic                multihLoop2xEn,
    input  logic                multihDemodLock,
    input  demodPkg::symbolT    iMultihLoop,
    input  demodPkg::symbolT    qMultihLoop,
    input  logic                demod0Sync,
    input  demodPkg::symbolT    demod0Data,
    input  logic                multihDac0Sync,
    input  demodPkg::symbolT    multihDac0Data,
    input  logic                multihDac0En,
    input  logic                demod1Sync,
    input  demodPkg::symbolT    demod1Data,
    input  logic                multihDac1Sync,
    input  demodPkg::symbolT    multihDac1Data,
    input  logic                multihDac1En,
    input  logic                demod2Sync,
    input  demodPkg::symbolT    demod2Data,
    input  logic                multihDac2Sync,
    input  demodPkg::symbolT    multihDac2Data,
    input  logic                multihDac2En,
    output logic                multihSymEn,
    output logic                multihSym2xEn,
    output demodPkg::symbolT    iMultihIn,
    output demodPkg::symbolT    qMultihIn,
    output logic                trellisSymEn,
    output logic                trellisSym2xEn,
    output demodPkg::symbolT    iTrellis,
    output demodPkg::symbolT    qTrellis,
    output logic                legacyBit,
    output logic                iData,
    output logic                qData,
    output logic                dataSymEn,
    output logic                dataSym2xEn,
    output logic                bsyncNLock,
    output logic                demodNLock,
    output demodPkg::dacWordT   dac0Data,
    output demodPkg::dacWordT   dac1Data,
    output demodPkg::dacWordT   dac2Data,
    output logic                dac0Sync,
    output logic                dac1Sync,
    output logic                dac2Sync,
    output demodPkg::bootAddrT  rebootAddr,
    output logic                rebootPulse,
    output logic                coreReset
);

    logic              miscWr;
    logic              miscRd;
    demodPkg::regWordT miscRdData;
    logic              multihMode;

    //**************************************************************************
    // Host registers
    //**************************************************************************

    hostDecode hostDecode (
        .clk(clk), .clockCounterEn(clockCounterEn),
        .addr(addr), .wrEn(wrEn), .rdEn(rdEn),
        .miscRdData(miscRdData), .demodRdData(demodRdData),
        .trellisRdData(trellisRdData), .sdiRdData(sdiRdData),
        .miscWr(miscWr), .miscRd(miscRd), .rdData(rdData)
    );

    miscRegs miscRegs (
        .clk(clk), .clockCounterEn(clockCounterEn),
        .addr(addr), .wrData(wrData), .miscWr(miscWr), .miscRd(miscRd),
        .miscRdData(miscRdData), .rebootAddr(rebootAddr),
        .rebootPulse(rebootPulse), .coreReset(coreReset)
    );

    //**************************************************************************
    // Symbol routing
    //**************************************************************************

    trellisRouter trellisRouter (
        .clk(clk), .clockCounterEn(clockCounterEn), .demodMode(demodMode),
        .trellisSymSync(trellisSymSync), .iSymEn(iSymEn), .iSym2xEn(iSym2xEn),
        .iBit(iBit), .qBit(qBit), .auBit(auBit),
        .carrierLock(carrierLock), .bitsyncLock(bitsyncLock),
        .iSymData(iSymData), .qSymData(qSymData),
        .multihLoopEn(multihLoopEn), .multihLoop2xEn(multihLoop2xEn),
        .multihDemodLock(multihDemodLock),
        .iMultihLoop(iMultihLoop), .qMultihLoop(qMultihLoop),
        .multihMode(multihMode),
        .multihSymEn(multihSymEn), .multihSym2xEn(multihSym2xEn),
        .iMultihIn(iMultihIn), .qMultihIn(qMultihIn),
        .trellisSymEn(trellisSymEn), .trellisSym2xEn(trellisSym2xEn),
        .iTrellis(iTrellis), .qTrellis(qTrellis), .legacyBit(legacyBit),
        .iData(iData), .qData(qData),
        .dataSymEn(dataSymEn), .dataSym2xEn(dataSym2xEn),
        .bsyncNLock(bsyncNLock), .demodNLock(demodNLock)
    );

    // DAC channels
    dacChannel dac0 (
        .clk(clk), .clockCounterEn(clockCounterEn), .multihMode(multihMode),
        .legacySync(demod0Sync), .legacyData(demod0Data),
        .multihSync(multihDac0Sync), .multihData(multihDac0Data),
        .multihEn(multihDac0En), .dacData(dac0Data), .dacSync(dac0Sync)
    );

    dacChannel dac1 (
        .clk(clk), .clockCounterEn(clockCounterEn), .multihMode(multihMode),
        .legacySync(demod1Sync), .legacyData(demod1Data),
        .multihSync(multihDac1Sync), .multihData(multihDac1Data),
        .multihEn(multihDac1En), .dacData(dac1Data), .dacSync(dac1Sync)
    );

    dacChannel dac2 (
        .clk(clk), .clockCounterEn(clockCounterEn), .multihMode(multihMode),
        .legacySync(demod2Sync), .legacyData(demod2Data),
        .multihSync(multihDac2Sync), .multihData(multihDac2Data),
        .multihEn(multihDac2En), .dacData(dac2Data), .dacSync(dac2Sync)
    );

endmodule

// File: hw/dacChannel.sv
// DAC output channel
`timescale 1ns/1ps

module dacChannel (
    input  logic              clk,
    input  logic              clockCounterEn,
    input  logic              multihMode,
    input  logic              legacySync,
    input  demodPkg::symbolT  legacyData,
    input  logic              multihSync,
    input  demodPkg::symbolT  multihData,
    input  logic              multihEn,
    output demodPkg::dacWordT dacData,
    output logic              dacSync
);

    demodPkg::symbolT stageData;
    logic             useMultih;

    assign useMultih = multihMode && multihEn;

    // Source stage
    always_ff @(posedge clk) begin
        stageData <= useMultih ? multihData : legacyData;
    end

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacSync <= 1'b0;
            dacData <= '0;
        end else begin
            dacSync <= useMultih ? multihSync : legacySync;
            // Upper bits only, word holds between syncs
            if (dacSync) begin
                dacData <= stageData[$bits(demodPkg::symbolT)-1:demodPkg::DAC_LSB];
            end
        end
    end

endmodule

// File: hw/trellisRouter.sv
// Trellis symbol routing
`timescale 1ns/1ps

module trellisRouter (
    input  logic                clk,
    input  logic                clockCounterEn,
    input  demodPkg::demodModeT demodMode,
    input  logic                trellisSymSync,
    input  logic                iSymEn,
    input  logic                iSym2xEn,
    input  logic                iBit,
    input  logic                qBit,
    input  logic                auBit,
    input  logic                carrierLock,
    input  logic                bitsyncLock,
    input  demodPkg::symbolT    iSymData,
    input  demodPkg::symbolT    qSymData,
    input  logic                multihLoopEn,
    input  logic                multihLoop2xEn,
    input  logic                multihDemodLock,
    input  demodPkg::symbolT    iMultihLoop,
    input  demodPkg::symbolT    qMultihLoop,
    output logic                multihMode,
    output logic                multihSymEn,
    output logic                multihSym2xEn,
    output demodPkg::symbolT    iMultihIn,
    output demodPkg::symbolT    qMultihIn,
    output logic                trellisSymEn,
    output logic                trellisSym2xEn,
    output demodPkg::symbolT    iTrellis,
    output demodPkg::symbolT    qTrellis,
    output logic                legacyBit,
    output logic                iData,
    output logic                qData,
    output logic                dataSymEn,
    output logic                dataSym2xEn,
    output logic                bsyncNLock,
    output logic                demodNLock
);

    logic fmModes;
    logic aModes;

    // Mode classes
    assign multihMode = (demodMode == demodPkg::MODE_MULTIH);
    assign fmModes = (demodMode == demodPkg::MODE_FM) || (demodMode == demodPkg::MODE_2FSK);
    assign aModes = (demodMode == demodPkg::MODE_AQPSK) ||
                    (demodMode == demodPkg::MODE_AUQPSK);

    // Strobes, loop feed only runs in multi-h
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            multihSymEn <= 1'b0;
            multihSym2xEn <= 1'b0;
            trellisSymEn <= 1'b0;
            trellisSym2xEn <= 1'b0;
            dataSymEn <= 1'b0;
            dataSym2xEn <= 1'b0;
        end else begin
            multihSymEn <= trellisSymSync && multihMode;
            multihSym2xEn <= iSym2xEn && multihMode;
            trellisSymEn <= multihMode ? multihLoopEn : trellisSymSync;
            trellisSym2xEn <= multihMode ? multihLoop2xEn : iSym2xEn;
            dataSymEn <= iSymEn;
            dataSym2xEn <= iSym2xEn;
        end
    end

    always_ff @(posedge clk) begin
        iMultihIn <= iSymData;
        qMultihIn <= qSymData;
        iTrellis <= multihMode ? iMultihLoop : iSymData;
        qTrellis <= multihMode ? qMultihLoop : qSymData;
        legacyBit <= iBit;
        // FM polarity is flipped, AQPSK takes the aux bit on Q
        iData <= fmModes ? !iBit : iBit;
        qData <= aModes ? auBit : qBit;
    end

    assign bsyncNLock = !bitsyncLock;
    assign demodNLock = multihMode ? !multihDemodLock : !carrierLock;

    multihFeedGated: assert property (@(posedge clk) disable iff (clockCounterEn)
        multihSymEn |-> $past(multihMode));

endmodule

// File: hw/miscRegs.sv
// Miscellaneous register space
`timescale 1ns/1ps

module miscRegs (
    input  logic               clk,
    input  logic               clockCounterEn,
    input  demodPkg::hostAddrT addr,
    input  demodPkg::hostDataT wrData,
    input  logic               miscWr,
    input  logic               miscRd,
    output demodPkg::regWordT  miscRdData,
    output demodPkg::bootAddrT rebootAddr,
    output logic               rebootPulse,
    output logic               coreReset
);

    localparam int RESET_CW = $clog2(demodPkg::RESET_STRETCH + 1);

    demodPkg::regOffsetT offset;
    logic                upperHalf;
    logic                clockWr;
    logic                clockLowRd;
    logic                bootLowWr;
    logic                bootHighWr;
    logic                resetRd;
    demodPkg::regWordT   clockCounter;
    demodPkg::regWordT   clockHold;
    logic                resetReq;
    logic [RESET_CW-1:0] resetCount;

    assign offset = addr[4:1];
    assign upperHalf = addr[0];

    assign clockWr = miscWr && (offset == demodPkg::MISC_CLOCK);
    assign clockLowRd = miscRd && (offset == demodPkg::MISC_CLOCK) && !upperHalf;
    assign bootLowWr = miscWr && (offset == demodPkg::REBOOT_ADDR) && !upperHalf;
    assign bootHighWr = miscWr && (offset == demodPkg::REBOOT_ADDR) && upperHalf;
    assign resetRd = miscRd && (offset == demodPkg::MISC_RESET);

    // Read word, low half of the clock is the live count
    always_comb begin
        case (offset)
            demodPkg::MISC_VERSION: miscRdData = {demodPkg::VER_NUMBER, 16'h0000};
            demodPkg::MISC_CLOCK:   miscRdData = {clockHold[31:16], clockCounter[15:0]};
            demodPkg::MISC_TYPE:    miscRdData = {16'h0000, demodPkg::LEGACY_IMAGE};
            demodPkg::REBOOT_ADDR:  miscRdData = {8'h00, rebootAddr};
            default:                miscRdData = '0;
        endcase
    end

    //**************************************************************************
    // Clock counter and soft reset
    //**************************************************************************

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            clockCounter <= '0;
            rebootPulse <= 1'b0;
            resetReq <= 1'b0;
            resetCount <= '0;
            coreReset <= 1'b0;
        end else begin
            // Restart on write, free running otherwise
            if (clockWr) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + 1'b1;
            end
            rebootPulse <= bootHighWr;
            resetReq <= resetRd;
            if (resetReq) begin
                coreReset <= 1'b1;
                resetCount <= RESET_CW'(demodPkg::RESET_STRETCH - 1);
            end else if (resetCount != '0) begin
                resetCount <= resetCount - 1'b1;
            end else begin
                coreReset <= 1'b0;
            end
        end
    end

    // Hold and boot address
    always_ff @(posedge clk) begin
        if (clockLowRd) begin
            clockHold <= clockCounter;
        end
        if (bootLowWr) begin
            rebootAddr[15:0] <= wrData;
        end
        if (bootHighWr) begin
            rebootAddr[23:16] <= wrData[7:0];
        end
    end

    // Reboot is a single clock pulse
    rebootPulseOnce: assert property (@(posedge clk) disable iff (clockCounterEn)
        rebootPulse |=> !rebootPulse);

    resetStretchMax: assert property (@(posedge clk) disable iff (clockCounterEn)
        $rose(coreReset) |-> ##(demodPkg::RESET_STRETCH) !coreReset);

endmodule

// File: hw/hostDecode.sv
// Host bus space decode
`timescale 1ns/1ps

module hostDecode (
    input  logic               clk,
    input  logic               clockCounterEn,
    input  demodPkg::hostAddrT addr,
    input  logic               wrEn,
    input  logic               rdEn,
    input  demodPkg::regWordT  miscRdData,
    input  demodPkg::regWordT  demodRdData,
    input  demodPkg::regWordT  trellisRdData,
    input  demodPkg::regWordT  sdiRdData,
    output logic               miscWr,
    output logic               miscRd,
    output demodPkg::hostDataT rdData
);

    demodPkg::spaceT    space;
    logic               miscSel;
    demodPkg::regWordT  selWord;
    demodPkg::hostDataT selHalf;

    // Space code sits in the top bits of the word address
    assign space = addr[11:5];
    assign miscSel = (space == demodPkg::MISC_SPACE);

    assign miscWr = wrEn && miscSel;
    assign miscRd = rdEn && miscSel;

    //**************************************************************************
    // Read data mux
    //**************************************************************************

    always_comb begin
        case (space)
            demodPkg::MISC_SPACE:    selWord = miscRdData;
            demodPkg::DEMOD_SPACE:   selWord = demodRdData;
            demodPkg::TRELLIS_SPACE: selWord = trellisRdData;
            demodPkg::SDI_SPACE:     selWord = sdiRdData;
            // Unmapped spaces read back as zero
            default:                 selWord = '0;
        endcase
    end

    // Bit 0 picks the upper half-word
    assign selHalf = addr[0] ? selWord[31:16] : selWord[15:0];

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            rdData <= '0;
        end else if (rdEn) begin
            rdData <= selHalf;
        end
    end

endmodule

// File: hw/demodPkg.sv
// Demodulator glue definitions
package demodPkg;

    // Host bus and register words
    typedef logic [11:0] hostAddrT;
    typedef logic [15:0] hostDataT;
    typedef logic [31:0] regWordT;
    typedef logic [6:0]  spaceT;
    typedef logic [3:0]  regOffsetT;

    // Sample paths
    typedef logic [17:0] symbolT;
    typedef logic [13:0] dacWordT;
    typedef logic [23:0] bootAddrT;

    // Address spaces, upper 7 bits of the word address
    localparam spaceT MISC_SPACE    = 7'h01;
    localparam spaceT DEMOD_SPACE   = 7'h02;
    localparam spaceT TRELLIS_SPACE = 7'h03;
    localparam spaceT SDI_SPACE     = 7'h04;

    // Misc space register offsets
    localparam regOffsetT MISC_RESET   = 4'd0;
    localparam regOffsetT MISC_VERSION = 4'd2;
    localparam regOffsetT MISC_CLOCK   = 4'd4;
    localparam regOffsetT MISC_TYPE    = 4'd6;
    localparam regOffsetT REBOOT_ADDR  = 4'd8;

    localparam hostDataT VER_NUMBER   = 16'h0185;
    localparam hostDataT LEGACY_IMAGE = 16'h0002;

    // Soft reset length in clocks
    localparam int RESET_STRETCH = 6;
    localparam int DAC_LSB       = 4;

    typedef enum logic [4:0] {
        MODE_FM         = 5'd0,
        MODE_2FSK       = 5'd1,
        MODE_AQPSK      = 5'd2,
        MODE_AUQPSK     = 5'd3,
        MODE_PCMTRELLIS = 5'd4,
        MODE_SOQPSK     = 5'd5,
        MODE_MULTIH     = 5'd6
    } demodModeT;

endpackage
